/* usb_pkg.sv */
`default_nettype none

package usb_pkg;

  // One byte of a packet stream with its end marker
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } stream_byte_t;

  // Kind is the upper half of the PID code
  typedef enum logic [1:0] {
    hsk_ack   = 2'b00,  // PID 0010
    hsk_nak   = 2'b10,  // PID 1010
    hsk_stall = 2'b11,  // PID 1110
    hsk_nyet  = 2'b01   // PID 0110
  } hsk_kind_e;

  typedef enum logic [1:0] {
    tok_out   = 2'b00,  // PID 0001
    tok_sof   = 2'b01,  // PID 0101
    tok_in    = 2'b10,  // PID 1001
    tok_setup = 2'b11   // PID 1101
  } tok_kind_e;

  typedef enum logic [1:0] {
    data_0 = 2'b00,  // PID 0011
    data_1 = 2'b10,  // PID 1011
    data_2 = 2'b01,  // PID 0111
    data_m = 2'b11   // PID 1111
  } data_kind_e;

  // Low two bits of the PID code
  localparam logic [1:0] pid_group_hsk  = 2'b10;
  localparam logic [1:0] pid_group_tok  = 2'b01;
  localparam logic [1:0] pid_group_data = 2'b11;

  localparam logic [15:0] crc16_residue_init = 16'hffff;

  // Check nibble on top, code in the low nibble
  function automatic logic [7:0] pid_byte(input logic [1:0] kind,
                                          input logic [1:0] group);
    logic [3:0] code;
    code = {kind, group};
    return {~code, code};
  endfunction

endpackage

`default_nettype wire

/* usb_crc16.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_crc16 (
  input  wire        clock,
  input  wire        reset,
  input  wire        clear_i,
  input  wire        enable_i,
  input  wire  [7:0] data_i,
  output logic [15:0] check_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_rev;

  // Poly 0x8005, data bits taken LSB first
  function automatic logic [15:0] crc16_step(input logic [15:0] crc,
                                             input logic [7:0]  data);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ data[i];
      c  = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h8005;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= usb_pkg::crc16_residue_init;
    end else if (enable_i) begin
      crc_q <= crc16_step(crc_q, data_i);
    end
  end

  // Low byte goes out on the wire first
  assign crc_rev = {<<{crc_q}};
  assign check_o = ~crc_rev;

endmodule

`default_nettype wire

/* usb_skid_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_skid_buffer (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         in_valid_i,
  output logic                        in_ready_o,
  input  wire usb_pkg::stream_byte_t  in_i,
  output logic                        out_valid_o,
  input  wire                         out_ready_i,
  output usb_pkg::stream_byte_t       out_o
);

  logic                  ready_q;
  logic                  out_valid_q;
  logic                  tmp_valid_q;
  usb_pkg::stream_byte_t out_q;
  usb_pkg::stream_byte_t tmp_q;

  logic in_fire;
  logic out_open;
  logic load_from_tmp;
  logic load_from_in;
  logic load_tmp;
  logic out_valid_d;
  logic tmp_valid_d;

  assign in_fire  = in_valid_i && ready_q;
  assign out_open = !out_valid_q || out_ready_i;  // Output register can take a byte

  always_comb begin
    load_from_tmp = out_open && tmp_valid_q;
    load_from_in  = out_open && !tmp_valid_q && in_fire;
    load_tmp      = !out_open && in_fire;  // Output stalled, park the byte
    out_valid_d   = out_open ? (tmp_valid_q || in_fire) : 1'b1;
    tmp_valid_d   = load_tmp || (tmp_valid_q && !out_open);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q     <= 1'b0;
      out_valid_q <= 1'b0;
      tmp_valid_q <= 1'b0;
    end else begin
      ready_q     <= !tmp_valid_d;
      out_valid_q <= out_valid_d;
      tmp_valid_q <= tmp_valid_d;
    end
  end

  always_ff @(posedge clock) begin
    if (load_from_tmp) begin
      out_q <= tmp_q;
    end else if (load_from_in) begin
      out_q <= in_i;
    end
    if (load_tmp) begin
      tmp_q <= in_i;
    end
  end

  assign in_ready_o  = ready_q;
  assign out_valid_o = out_valid_q;
  assign out_o       = out_q;

endmodule

`default_nettype wire

/* usb_packet_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_packet_encoder #(
  parameter bit token_enable = 1'b1
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         hsk_send_i,
  input  wire usb_pkg::hsk_kind_e     hsk_kind_i,
  output logic                        hsk_done_o,
  input  wire                         tok_send_i,
  input  wire usb_pkg::tok_kind_e     tok_kind_i,
  input  wire  [15:0]                 tok_data_i,
  output logic                        tok_done_o,
  input  wire                         data_send_i,
  input  wire usb_pkg::data_kind_e    data_kind_i,
  output logic                        data_done_o,
  input  wire                         skid_valid_i,
  output logic                        skid_ready_o,
  input  wire usb_pkg::stream_byte_t  skid_i,
  output logic                        crc_clear_o,
  output logic                        crc_enable_o,
  input  wire  [15:0]                 crc_check_i,
  output logic                        tx_valid_o,
  input  wire                         tx_ready_i,
  output usb_pkg::stream_byte_t       tx_o
);

  // One-hot state bit positions
  localparam int unsigned idx_idle = 0;
  localparam int unsigned idx_hsk  = 1;
  localparam int unsigned idx_tok  = 2;
  localparam int unsigned idx_data = 3;

  logic [3:0]            state_q, state_d;
  usb_pkg::stream_byte_t tx_q, tx_d;
  logic                  tx_valid_q, tx_valid_d;
  logic                  head_q, head_d;            // PID of a data packet in tx_q
  logic                  pay_end_q, pay_end_d;      // Final payload byte loaded
  logic                  crc_phase_q, crc_phase_d;  // Sending CRC bytes
  logic                  tok_high_q, tok_high_d;
  logic                  hsk_done_q, tok_done_q, data_done_q;

  logic tx_take;
  logic tx_free;
  logic skid_fire;

  assign tx_take   = tx_valid_q && tx_ready_i;
  assign tx_free   = !tx_valid_q || tx_ready_i;
  assign skid_fire = skid_valid_i && skid_ready_o;

  assign skid_ready_o = state_q[idx_data] && !pay_end_q && !crc_phase_q && tx_free;
  assign crc_clear_o  = state_q[idx_idle];
  assign crc_enable_o = skid_fire;

  always_comb begin
    state_d     = state_q;
    tx_d        = tx_q;
    tx_valid_d  = tx_valid_q;
    head_d      = head_q;
    pay_end_d   = pay_end_q;
    crc_phase_d = crc_phase_q;
    tok_high_d  = tok_high_q;
    case (1'b1)
      state_q[idx_hsk]: begin
        if (tx_take) begin
          tx_valid_d = 1'b0;
          state_d    = 4'b1 << idx_idle;
        end
      end
      state_q[idx_tok]: begin
        if (tx_take) begin
          if (tx_q.last) begin
            tx_valid_d = 1'b0;
            state_d    = 4'b1 << idx_idle;
          end else begin
            tx_d.data  = tok_high_q ? tok_data_i[15:8] : tok_data_i[7:0];
            tx_d.last  = tok_high_q;
            tok_high_d = 1'b1;
          end
        end
      end
      state_q[idx_data]: begin
        if (crc_phase_q) begin
          if (tx_take && tx_q.last) begin
            tx_valid_d  = 1'b0;
            crc_phase_d = 1'b0;
            state_d     = 4'b1 << idx_idle;
          end else if (tx_take) begin
            tx_d.data = crc_check_i[15:8];
            tx_d.last = 1'b1;
          end
        end else if (tx_take && (pay_end_q || (head_q && !skid_valid_i))) begin
          // No payload waiting behind the PID means a zero-length packet
          tx_d.data   = crc_check_i[7:0];
          tx_d.last   = 1'b0;
          crc_phase_d = 1'b1;
          pay_end_d   = 1'b0;
          head_d      = 1'b0;
        end else if (skid_fire) begin
          tx_d.data  = skid_i.data;
          tx_d.last  = 1'b0;  // CRC still follows
          tx_valid_d = 1'b1;
          pay_end_d  = skid_i.last;
          head_d     = 1'b0;
        end else if (tx_take) begin
          tx_valid_d = 1'b0;  // Gap in the payload stream
        end
      end
      default: begin
        if (hsk_send_i && !hsk_done_q) begin
          state_d    = 4'b1 << idx_hsk;
          tx_d.data  = usb_pkg::pid_byte(hsk_kind_i, usb_pkg::pid_group_hsk);
          tx_d.last  = 1'b1;
          tx_valid_d = 1'b1;
        end else if (token_enable && tok_send_i && !tok_done_q) begin
          state_d    = 4'b1 << idx_tok;
          tx_d.data  = usb_pkg::pid_byte(tok_kind_i, usb_pkg::pid_group_tok);
          tx_d.last  = 1'b0;
          tx_valid_d = 1'b1;
          tok_high_d = 1'b0;
        end else if (data_send_i && !data_done_q) begin
          state_d     = 4'b1 << idx_data;
          tx_d.data   = usb_pkg::pid_byte(data_kind_i, usb_pkg::pid_group_data);
          tx_d.last   = 1'b0;
          tx_valid_d  = 1'b1;
          head_d      = 1'b1;
          pay_end_d   = 1'b0;
          crc_phase_d = 1'b0;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= 4'b1 << idx_idle;
      tx_valid_q  <= 1'b0;
      head_q      <= 1'b0;
      pay_end_q   <= 1'b0;
      crc_phase_q <= 1'b0;
      tok_high_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      tx_valid_q  <= tx_valid_d;
      head_q      <= head_d;
      pay_end_q   <= pay_end_d;
      crc_phase_q <= crc_phase_d;
      tok_high_q  <= tok_high_d;
    end
  end

  always_ff @(posedge clock) begin
    tx_q <= tx_d;
  end

  // Handshake and token done hold until send drops, data done is a pulse
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_done_q  <= 1'b0;
      tok_done_q  <= 1'b0;
      data_done_q <= 1'b0;
    end else begin
      if (!hsk_send_i) begin
        hsk_done_q <= 1'b0;
      end else if (state_q[idx_hsk] && tx_take) begin
        hsk_done_q <= 1'b1;
      end
      if (!token_enable || !tok_send_i) begin
        tok_done_q <= 1'b0;
      end else if (state_q[idx_tok] && tx_take && tx_q.last) begin
        tok_done_q <= 1'b1;
      end
      data_done_q <= state_q[idx_data] && crc_phase_q && tx_take && tx_q.last;
    end
  end

  assign hsk_done_o  = hsk_done_q;
  assign tok_done_o  = tok_done_q;
  assign data_done_o = data_done_q;
  assign tx_valid_o  = tx_valid_q;
  assign tx_o        = tx_q;

endmodule

`default_nettype wire

/* usb_tx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module usb_tx_top #(
  parameter bit token_enable = 1'b1
) (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         hsk_send_i,
  input  wire usb_pkg::hsk_kind_e     hsk_kind_i,
  output wire                         hsk_done_o,
  input  wire                         tok_send_i,
  input  wire usb_pkg::tok_kind_e     tok_kind_i,
  input  wire  [15:0]                 tok_data_i,
  output wire                         tok_done_o,
  input  wire                         data_send_i,
  input  wire usb_pkg::data_kind_e    data_kind_i,
  output wire                         data_done_o,
  input  wire                         payload_valid_i,
  output wire                         payload_ready_o,
  input  wire usb_pkg::stream_byte_t  payload_i,
  output wire                         tx_valid_o,
  input  wire                         tx_ready_i,
  output wire usb_pkg::stream_byte_t  tx_o
);

  wire                        skid_valid;
  wire                        skid_ready;
  wire usb_pkg::stream_byte_t skid_byte;
  wire                        crc_clear;
  wire                        crc_enable;
  wire [15:0]                 crc_check;

  usb_skid_buffer i_skid (
    .clock       (clock),
    .reset       (reset),
    .in_valid_i  (payload_valid_i),
    .in_ready_o  (payload_ready_o),
    .in_i        (payload_i),
    .out_valid_o (skid_valid),
    .out_ready_i (skid_ready),
    .out_o       (skid_byte)
  );

  // Folds in each payload byte as the encoder accepts it
  usb_crc16 i_crc (
    .clock    (clock),
    .reset    (reset),
    .clear_i  (crc_clear),
    .enable_i (crc_enable),
    .data_i   (skid_byte.data),
    .check_o  (crc_check)
  );

  usb_packet_encoder #(
    .token_enable (token_enable)
  ) i_encoder (
    .clock        (clock),
    .reset        (reset),
    .hsk_send_i   (hsk_send_i),
    .hsk_kind_i   (hsk_kind_i),
    .hsk_done_o   (hsk_done_o),
    .tok_send_i   (tok_send_i),
    .tok_kind_i   (tok_kind_i),
    .tok_data_i   (tok_data_i),
    .tok_done_o   (tok_done_o),
    .data_send_i  (data_send_i),
    .data_kind_i  (data_kind_i),
    .data_done_o  (data_done_o),
    .skid_valid_i (skid_valid),
    .skid_ready_o (skid_ready),
    .skid_i       (skid_byte),
    .crc_clear_o  (crc_clear),
    .crc_enable_o (crc_enable),
    .crc_check_i  (crc_check),
    .tx_valid_o   (tx_valid_o),
    .tx_ready_i   (tx_ready_i),
    .tx_o         (tx_o)
  );

endmodule

`default_nettype wire

/* tb_usb_tx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_usb_tx;

  localparam logic [31:0] lfsr_seed = 32'hcdcb626f;
  // 83 packet bytes plus 12 idle cycles for each of 16 packets
  localparam int watchdog_cycles = 4 * (83 + 12 * 16);
  localparam int done_limit = 200;

  typedef usb_pkg::stream_byte_t byte_q_t[$];

  logic                  clock;
  logic                  reset;
  logic                  hsk_send;
  logic                  tok_send;
  logic                  data_send;
  usb_pkg::hsk_kind_e    hsk_kind;
  usb_pkg::tok_kind_e    tok_kind;
  usb_pkg::data_kind_e   data_kind;
  logic [15:0]           tok_data;
  logic                  hsk_done;
  logic                  tok_done;
  logic                  data_done;
  logic                  payload_valid;
  logic                  payload_ready;
  usb_pkg::stream_byte_t payload;
  logic                  tx_valid;
  logic                  tx_ready;
  usb_pkg::stream_byte_t tx_byte;

  usb_pkg::stream_byte_t got_q[$];
  logic [31:0]           data_lfsr = lfsr_seed;   // Payload and token values
  logic [31:0]           ready_lfsr = lfsr_seed;  // Back-pressure pattern
  logic                  random_ready;
  int                    errors = 0;
  int                    checks = 0;
  int                    data_pulses = 0;

  usb_tx_top #(
    .token_enable (1'b1)
  ) i_dut (
    .clock           (clock),
    .reset           (reset),
    .hsk_send_i      (hsk_send),
    .hsk_kind_i      (hsk_kind),
    .hsk_done_o      (hsk_done),
    .tok_send_i      (tok_send),
    .tok_kind_i      (tok_kind),
    .tok_data_i      (tok_data),
    .tok_done_o      (tok_done),
    .data_send_i     (data_send),
    .data_kind_i     (data_kind),
    .data_done_o     (data_done),
    .payload_valid_i (payload_valid),
    .payload_ready_o (payload_ready),
    .payload_i       (payload),
    .tx_valid_o      (tx_valid),
    .tx_ready_i      (tx_ready),
    .tx_o            (tx_byte)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    if (tx_valid && tx_ready) begin
      got_q.push_back(tx_byte);
    end
    if (data_done) begin
      data_pulses++;
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    tx_ready <= 1'b0;
    forever begin
      @(posedge clock);
      if (random_ready) begin
        ready_lfsr = lfsr_step(ready_lfsr);
        tx_ready <= ready_lfsr[0];
      end else begin
        tx_ready <= 1'b1;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout: run did not finish within %0d cycles, errors so far %0d",
             watchdog_cycles, errors);
    $display("tests failed");
    $finish;
  end

  function automatic logic [7:0] next_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      data_lfsr = lfsr_step(data_lfsr);
      b[i] = data_lfsr[0];
    end
    return b;
  endfunction

  function automatic usb_pkg::stream_byte_t make_byte(input logic [7:0] d, input logic l);
    usb_pkg::stream_byte_t sb;
    sb.data = d;
    sb.last = l;
    return sb;
  endfunction

  // Check nibble is the complement of the code
  function automatic logic [7:0] pid_ref(input logic [3:0] code);
    return {~code, code};
  endfunction

  // Reflected form of poly 0x8005, so bits enter LSB first
  function automatic logic [15:0] crc_ref(input logic [7:0] bytes[$]);
    logic [15:0] crc;
    crc = 16'hffff;
    foreach (bytes[i]) begin
      for (int b = 0; b < 8; b++) begin
        if (crc[0] ^ bytes[i][b]) begin
          crc = (crc >> 1) ^ 16'ha001;
        end else begin
          crc = crc >> 1;
        end
      end
    end
    return ~crc;
  endfunction

  function automatic byte_q_t data_packet(input logic [3:0] code, input logic [7:0] bytes[$]);
    byte_q_t     q;
    logic [15:0] crc;
    crc = crc_ref(bytes);
    q.push_back(make_byte(pid_ref(code), 1'b0));
    foreach (bytes[i]) begin
      q.push_back(make_byte(bytes[i], 1'b0));  // Payload last never reaches the wire
    end
    q.push_back(make_byte(crc[7:0], 1'b0));
    q.push_back(make_byte(crc[15:8], 1'b1));
    return q;
  endfunction

  function automatic logic done_of(input int which);
    case (which)
      0:       return hsk_done;
      1:       return tok_done;
      default: return data_done;
    endcase
  endfunction

  task automatic set_send(input int which, input logic value);
    case (which)
      0:       hsk_send <= value;
      1:       tok_send <= value;
      default: data_send <= value;
    endcase
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_stream(input string name, input byte_q_t exp_q);
    checks++;
    assert (got_q.size() == exp_q.size()) else begin
      errors++;
      $display("Mismatch %s byte count: expected %0d, actual %0d",
               name, exp_q.size(), got_q.size());
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      checks++;
      assert (got_q[i] == exp_q[i]) else begin
        errors++;
        $display("Mismatch %s byte %0d: expected %h last %b, actual %h last %b", name, i,
                 exp_q[i].data, exp_q[i].last, got_q[i].data, got_q[i].last);
      end
    end
  endtask

  task automatic wait_done(input int which, input string name);
    logic found;
    found = 1'b0;
    for (int n = 0; n < done_limit && !found; n++) begin
      @(posedge clock);
      found = done_of(which);
    end
    assert (found) else begin
      errors++;
      $display("%s: done never came within %0d cycles", name, done_limit);
    end
  endtask

  task automatic feed_payload(input logic [7:0] bytes[$]);
    for (int i = 0; i < bytes.size(); i++) begin
      payload_valid <= 1'b1;
      payload <= make_byte(bytes[i], i == bytes.size() - 1);
      do @(posedge clock); while (!payload_ready);
    end
    payload_valid <= 1'b0;
  endtask

  // Handshake and token done must hold while send is high, then fall
  task automatic run_level(input int which, input string name, input byte_q_t exp_q);
    got_q.delete();
    set_send(which, 1'b1);
    wait_done(which, name);
    @(posedge clock);
    check_bit({name, " done held"}, 1'b1, done_of(which));
    set_send(which, 1'b0);
    repeat (2) @(posedge clock);
    check_bit({name, " done released"}, 1'b0, done_of(which));
    check_stream(name, exp_q);
  endtask

  task automatic run_data(input string name, input usb_pkg::data_kind_e kind,
                          input logic [3:0] code, input logic [7:0] pay_q[$]);
    got_q.delete();
    data_pulses = 0;
    data_kind <= kind;
    data_send <= 1'b1;
    fork
      feed_payload(pay_q);
      begin
        wait_done(2, name);
        data_send <= 1'b0;  // Drop on the pulse
      end
    join
    repeat (3) @(posedge clock);
    checks++;
    assert (data_pulses == 1) else begin
      errors++;
      $display("Mismatch %s done pulses: expected 1, actual %0d", name, data_pulses);
    end
    check_stream(name, data_packet(code, pay_q));
  endtask

  task automatic test_handshakes();
    usb_pkg::hsk_kind_e kinds[4];
    logic [3:0]         codes[4];
    byte_q_t            exp_q;
    kinds = '{usb_pkg::hsk_ack, usb_pkg::hsk_nak, usb_pkg::hsk_stall, usb_pkg::hsk_nyet};
    codes = '{4'b0010, 4'b1010, 4'b1110, 4'b0110};
    for (int k = 0; k < 4; k++) begin
      exp_q.delete();
      exp_q.push_back(make_byte(pid_ref(codes[k]), 1'b1));
      hsk_kind <= kinds[k];
      run_level(0, "handshake", exp_q);
    end
  endtask

  task automatic test_tokens();
    usb_pkg::tok_kind_e kinds[4];
    logic [3:0]         codes[4];
    logic [15:0]        value;
    byte_q_t            exp_q;
    kinds = '{usb_pkg::tok_out, usb_pkg::tok_sof, usb_pkg::tok_in, usb_pkg::tok_setup};
    codes = '{4'b0001, 4'b0101, 4'b1001, 4'b1101};
    for (int k = 0; k < 4; k++) begin
      value[7:0]  = next_byte();
      value[15:8] = next_byte();
      exp_q.delete();
      exp_q.push_back(make_byte(pid_ref(codes[k]), 1'b0));
      exp_q.push_back(make_byte(value[7:0], 1'b0));
      exp_q.push_back(make_byte(value[15:8], 1'b1));
      tok_kind <= kinds[k];
      tok_data <= value;
      run_level(1, "token", exp_q);
    end
  endtask

  task automatic test_data_steady();
    usb_pkg::data_kind_e kinds[3];
    logic [3:0]          codes[3];
    int                  lens[3];
    logic [7:0]          pay_q[$];
    kinds = '{usb_pkg::data_0, usb_pkg::data_1, usb_pkg::data_2};
    codes = '{4'b0011, 4'b1011, 4'b0111};
    lens  = '{1, 5, 16};
    for (int k = 0; k < 3; k++) begin
      pay_q.delete();
      repeat (lens[k]) pay_q.push_back(next_byte());
      run_data("data steady", kinds[k], codes[k], pay_q);
    end
  endtask

  task automatic test_zero_length();
    logic [7:0] pay_q[$];
    run_data("zero length", usb_pkg::data_1, 4'b1011, pay_q);  // Expect PID, 0x00, 0x00
  endtask

  task automatic test_back_pressure();
    logic [7:0] pay_q[$];
    repeat (20) pay_q.push_back(next_byte());
    random_ready <= 1'b1;
    @(posedge clock);
    run_data("back pressure", usb_pkg::data_m, 4'b1111, pay_q);
    random_ready <= 1'b0;
    @(posedge clock);
  endtask

  task automatic test_priority();
    logic [7:0]  pay_q[$];
    logic [15:0] value;
    byte_q_t     exp_q;
    repeat (3) pay_q.push_back(next_byte());
    value[7:0]  = next_byte();
    value[15:8] = next_byte();
    exp_q = data_packet(4'b0011, pay_q);
    exp_q.push_front(make_byte(value[15:8], 1'b1));
    exp_q.push_front(make_byte(value[7:0], 1'b0));
    exp_q.push_front(make_byte(pid_ref(4'b1001), 1'b0));
    exp_q.push_front(make_byte(pid_ref(4'b1110), 1'b1));
    got_q.delete();
    hsk_kind  <= usb_pkg::hsk_stall;
    tok_kind  <= usb_pkg::tok_in;
    tok_data  <= value;
    data_kind <= usb_pkg::data_0;
    for (int w = 0; w < 3; w++) begin
      set_send(w, 1'b1);
    end
    fork
      begin
        wait_done(0, "priority handshake");
        set_send(0, 1'b0);
      end
      begin
        wait_done(1, "priority token");
        set_send(1, 1'b0);
      end
      begin
        wait_done(2, "priority data");
        set_send(2, 1'b0);
      end
      feed_payload(pay_q);
    join
    repeat (3) @(posedge clock);
    check_stream("priority", exp_q);
  endtask

  initial begin
    reset         <= 1'b1;
    hsk_send      <= 1'b0;
    tok_send      <= 1'b0;
    data_send     <= 1'b0;
    hsk_kind      <= usb_pkg::hsk_ack;
    tok_kind      <= usb_pkg::tok_out;
    data_kind     <= usb_pkg::data_0;
    tok_data      <= '0;
    payload_valid <= 1'b0;
    payload       <= '0;
    random_ready  <= 1'b0;
    repeat (3) @(posedge clock);
    check_bit("reset tx_valid", 1'b0, tx_valid);
    check_bit("reset payload_ready", 1'b0, payload_ready);
    check_bit("reset hsk_done", 1'b0, hsk_done);
    check_bit("reset tok_done", 1'b0, tok_done);
    check_bit("reset data_done", 1'b0, data_done);
    reset <= 1'b0;
    @(posedge clock);
    test_handshakes();
    test_tokens();
    test_data_steady();
    test_zero_length();
    test_back_pressure();
    test_priority();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
usb_pkg.sv
usb_crc16.sv
usb_skid_buffer.sv
usb_packet_encoder.sv
usb_tx_top.sv
tb_usb_tx.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_usb_tx -f sources.f -o sim_usb_tx

out=$(./obj_dir/sim_usb_tx)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
